// File: verilog/decode_consts.svh
/* 8086 front-end decoder constants
   Register numbers and ModR/M field codes shared by the decode blocks */

`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Register numbers used in effective-address results
`define REG_BX   4'b0011
`define REG_BP   4'b0101
`define REG_SI   4'b0110
`define REG_DI   4'b0111

// The high bit is set when a register takes no part in the address
`define REG_NONE 4'b1100

// ModR/M field codes
`define RM_DIRECT 3'b110 // With mod 00 this is a 16-bit direct address
`define MOD_REG   2'b11  // Register operand, no memory access

`endif

// File: verilog/decode_pkg.sv
/* Decoder types
   Register number, segment code and the full decoded result */

package decode_pkg;

    typedef logic [3:0] reg_id_t; // High bit set means unused

    typedef enum logic [1:0]
    {
        SEG_ES = 2'b00,
        SEG_CS = 2'b01,
        SEG_SS = 2'b10,
        SEG_DS = 2'b11
    } seg_t;

    // Everything the front end reports for one opcode/ModR/M pair
    typedef struct packed
    {
        logic    need_modrm;
        logic    need_disp;
        logic    disp_size;   // 0 is 8 bit, 1 is 16 bit
        logic    need_imm;
        logic    imm_size;    // 0 is 8 bit, 1 is 16 bit
        logic    word_op;     // Operand width from w
        logic    not_decoded;
        reg_id_t src;
        reg_id_t dst;
        reg_id_t base;        // Effective-address base
        reg_id_t index;       // Effective-address index
        seg_t    seg;         // Default segment
    } decode_t;

endpackage

// File: verilog/ea_if.sv
/* Effective-address bundle
   Carries base, index, segment and displacement needs out of the ModR/M decoder */

`timescale 1ns/1ps

interface ea_if;

    logic [3:0] base;
    logic [3:0] index;
    logic [1:0] seg;
    logic       disp_mod;      // Mod/rm call for a displacement
    logic       disp_wide_mod; // That displacement is 16 bits

    modport source (output base, index, seg, disp_mod, disp_wide_mod);

    modport sink (input base, index, seg, disp_mod, disp_wide_mod);

endinterface

// File: verilog/modrm_decode.sv
/* ModR/M effective-address decoder
   Maps mod and rm onto base, index, default segment and displacement needs */

`timescale 1ns/1ps

`include "decode_consts.svh"

module modrm_decode
(
    input  logic [7:0] modrm,
    ea_if.source       ea
);

    logic [1:0] mod;
    logic [2:0] rm;
    logic       direct;

    assign mod    = modrm[7:6];
    assign rm     = modrm[2:0];
    assign direct = (mod == 2'b00) && (rm == `RM_DIRECT); // disp16 only, no registers

    // Mod 01 and 10 carry a displacement; 11 is a register operand
    assign ea.disp_mod      = direct || ((mod != 2'b00) && (mod != `MOD_REG));
    assign ea.disp_wide_mod = direct ? 1'b1 : mod[1];

    // BP-based modes default to the stack segment
    always_comb
    begin
        case (rm)
            3'b000:
            begin
                ea.base  = `REG_BX;
                ea.index = `REG_SI;
                ea.seg   = decode_pkg::SEG_DS;
            end
            3'b001:
            begin
                ea.base  = `REG_BX;
                ea.index = `REG_DI;
                ea.seg   = decode_pkg::SEG_DS;
            end
            3'b010:
            begin
                ea.base  = `REG_BP;
                ea.index = `REG_SI;
                ea.seg   = decode_pkg::SEG_SS;
            end
            3'b011:
            begin
                ea.base  = `REG_BP;
                ea.index = `REG_DI;
                ea.seg   = decode_pkg::SEG_SS;
            end
            3'b100:
            begin
                ea.base  = `REG_NONE;
                ea.index = `REG_SI;
                ea.seg   = decode_pkg::SEG_DS;
            end
            3'b101:
            begin
                ea.base  = `REG_NONE;
                ea.index = `REG_DI;
                ea.seg   = decode_pkg::SEG_DS;
            end
            3'b110:
            begin
                ea.base  = direct ? `REG_NONE : `REG_BP;
                ea.index = `REG_NONE;
                ea.seg   = direct ? decode_pkg::SEG_DS : decode_pkg::SEG_SS;
            end
            default:
            begin
                ea.base  = `REG_BX; // rm 111
                ea.index = `REG_NONE;
                ea.seg   = decode_pkg::SEG_DS;
            end
        endcase
    end

endmodule

// File: verilog/opcode_decode.sv
/* Opcode classifier
   Matches the kept 8086 opcode groups and assembles the complete decoded result */

`timescale 1ns/1ps

module opcode_decode
(
    input  logic [7:0]          opcode,
    input  logic [7:0]          modrm,
    ea_if.sink                  ea,
    output decode_pkg::decode_t result
);

    logic [2:0]          reg_f;
    logic [2:0]          rm;
    decode_pkg::reg_id_t dst_rm;
    decode_pkg::reg_id_t src_rm;
    decode_pkg::reg_id_t rm_id;

    assign reg_f = modrm[5:3];
    assign rm    = modrm[2:0];
    assign rm_id = {1'b0, rm};

    // Direction bit picks which field is written
    assign dst_rm = opcode[1] ? {1'b0, reg_f} : rm_id;
    assign src_rm = opcode[1] ? rm_id : {1'b0, reg_f};

    always_comb
    begin
        result = '0;

        // MOV reg-immediate keeps w in bit 3
        result.word_op = (opcode[7:4] == 4'b1011) ? opcode[3] : opcode[0];

        result.base  = ea.base;
        result.index = ea.index;
        result.seg   = decode_pkg::seg_t'(ea.seg);

        casez (opcode)
            8'b00??_?0??, // ALU r/m, reg
            8'b1000_01??, // TEST, XCHG
            8'b1000_10??: // MOV r/m, reg
            begin
                result.need_modrm = 1'b1;
                result.need_disp  = ea.disp_mod;
                result.disp_size  = ea.disp_wide_mod;
                result.dst        = dst_rm;
                result.src        = src_rm;
            end

            8'b00??_?10?: // ALU accumulator, imm
            begin
                result.need_imm = 1'b1;
                result.imm_size = opcode[0];
            end

            8'b010?_????: // INC/DEC/PUSH/POP reg16
            begin
                result.src = {1'b0, opcode[2:0]};
            end

            8'b0111_????, // Jcc short
            8'hEB:        // JMP short
            begin
                result.need_disp = 1'b1;
            end

            8'hE8, // CALL near
            8'hE9: // JMP near
            begin
                result.need_disp = 1'b1;
                result.disp_size = 1'b1;
            end

            8'b1000_00??: // Group 1 r/m, imm
            begin
                result.need_modrm = 1'b1;
                result.need_disp  = ea.disp_mod;
                result.disp_size  = ea.disp_wide_mod;
                result.need_imm   = 1'b1;
                result.imm_size   = ~opcode[1] & opcode[0]; // Sign-extended imm8 when s set
                result.dst        = rm_id;
            end

            8'b1011_????: // MOV reg, imm
            begin
                result.need_imm = 1'b1;
                result.imm_size = opcode[3];
                result.dst      = {1'b0, opcode[2:0]};
            end

            8'b1101_00??: // Shift/rotate by 1 or CL
            begin
                result.need_modrm = 1'b1;
                result.need_disp  = ea.disp_mod;
                result.disp_size  = ea.disp_wide_mod;
                result.dst        = rm_id;
                result.src        = rm_id;
            end

            default:
            begin
                result.not_decoded = 1'b1;
            end
        endcase
    end

endmodule

// File: verilog/decode_register.sv
/* Decoder output stage
   Captures the decoded result on each strobe and pulses decoded_valid a cycle later */

`timescale 1ns/1ps

module decode_register
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  decode_pkg::decode_t next,
    output decode_pkg::decode_t decoded,
    output logic                decoded_valid
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            decoded       <= '0;
            decoded_valid <= 1'b0;
        end
        else
        begin
            decoded_valid <= instr_valid; // One pulse per strobe
            if (instr_valid)
            begin
                decoded <= next;
            end
        end
    end

endmodule

// File: verilog/decode_top.sv
/* 8086 front-end decoder top level
   ModR/M and opcode decoding followed by one output register stage */

`timescale 1ns/1ps

module decode_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  logic [7:0]          opcode,
    input  logic [7:0]          modrm,
    output logic                need_modrm,
    output logic                need_disp,
    output logic                disp_size,
    output logic                need_imm,
    output logic                imm_size,
    output logic                word_op,
    output logic                not_decoded,
    output decode_pkg::reg_id_t src,
    output decode_pkg::reg_id_t dst,
    output decode_pkg::reg_id_t base,
    output decode_pkg::reg_id_t index,
    output decode_pkg::seg_t    seg,
    output logic                decoded_valid
);

    decode_pkg::decode_t next_result;
    decode_pkg::decode_t decoded;

    ea_if ea_i ();

    modrm_decode modrm_i
    (
        .modrm (modrm),
        .ea    (ea_i.source)
    );

    opcode_decode opcode_i
    (
        .opcode (opcode),
        .modrm  (modrm),
        .ea     (ea_i.sink),
        .result (next_result)
    );

    decode_register register_i
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .next          (next_result),
        .decoded       (decoded),
        .decoded_valid (decoded_valid)
    );

    assign need_modrm  = decoded.need_modrm;
    assign need_disp   = decoded.need_disp;
    assign disp_size   = decoded.disp_size;
    assign need_imm    = decoded.need_imm;
    assign imm_size    = decoded.imm_size;
    assign word_op     = decoded.word_op;
    assign not_decoded = decoded.not_decoded;
    assign src         = decoded.src;
    assign dst         = decoded.dst;
    assign base        = decoded.base;
    assign index       = decoded.index;
    assign seg         = decoded.seg;

endmodule

// File: bench/decode_assert.sv
/* Output stage assertions
   Reset, not_decoded and immediate-size rules on the registered result */

`timescale 1ns/1ps

module decode_assert
(
    input logic                clk,
    input logic                rst_n,
    input decode_pkg::decode_t decoded,
    input logic                decoded_valid
);

    int fail_count = 0; // Read by the testbench at the end

    valid_after_reset: assert property (@(posedge clk) !rst_n |=> !decoded_valid)
    else
    begin
        $error("decoded_valid high in the cycle after a reset edge");
        fail_count++;
    end

    undecoded_clean: assert property (@(posedge clk)
        decoded.not_decoded |-> !(decoded.need_modrm || decoded.need_disp || decoded.need_imm))
    else
    begin
        $error("not_decoded result still requests further bytes");
        fail_count++;
    end

    imm_size_needs_imm: assert property (@(posedge clk) !decoded.need_imm |-> !decoded.imm_size)
    else
    begin
        $error("imm_size set without need_imm");
        fail_count++;
    end

endmodule

bind decode_register decode_assert assert_i
(
    .clk           (clk),
    .rst_n         (rst_n),
    .decoded       (decoded),
    .decoded_valid (decoded_valid)
);

// File: bench/decode_checker.sv
/* Decoder scoreboard
   Queues strobed inputs and compares each decoded_valid against a reference model */

`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_checker
(
    input logic                clk,
    input logic                rst_n,
    input logic                instr_valid,
    input logic [7:0]          opcode,
    input logic [7:0]          modrm,
    input logic [3:0]          test_id,
    input logic                need_modrm,
    input logic                need_disp,
    input logic                disp_size,
    input logic                need_imm,
    input logic                imm_size,
    input logic                word_op,
    input logic                not_decoded,
    input decode_pkg::reg_id_t src,
    input decode_pkg::reg_id_t dst,
    input decode_pkg::reg_id_t base,
    input decode_pkg::reg_id_t index,
    input decode_pkg::seg_t    seg,
    input logic                decoded_valid
);

    logic [19:0]         pending[$]; // Test id, opcode, modrm
    logic [19:0]         entry;
    decode_pkg::decode_t actual;
    decode_pkg::decode_t held;
    logic                armed      = 1'b0; // Set by the first reset edge
    logic                reset_seen = 1'b0;
    logic                strobed    = 1'b0; // Strobe accepted on the previous edge
    int                  error_count = 0;
    int                  check_count = 0;

    assign actual = {need_modrm, need_disp, disp_size, need_imm, imm_size, word_op,
                     not_decoded, src, dst, base, index, seg};

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "ea_sweep_d0";
            4'd2:    return "ea_sweep_d1";
            4'd3:    return "opcode_sweep";
            4'd4:    return "random";
            4'd5:    return "after_reset";
            default: return "unknown";
        endcase
    endfunction

    function automatic decode_pkg::decode_t expected_decode(input logic [7:0] op,
                                                            input logic [7:0] m);
        decode_pkg::decode_t r;
        logic [1:0]          md;
        logic [2:0]          rg;
        logic [2:0]          rmf;
        logic                direct;
        logic                mem_form;
        logic                d_form;
        md       = m[7:6];
        rg       = m[5:3];
        rmf      = m[2:0];
        direct   = (md == 2'b00) && (rmf == 3'b110);
        mem_form = 1'b0;
        d_form   = 1'b0;
        r        = '0;

        if (!rmf[2])
            r.base = rmf[1] ? `REG_BP : `REG_BX;
        else if (!rmf[1])
            r.base = `REG_NONE;
        else if (rmf[0])
            r.base = `REG_BX;
        else
            r.base = direct ? `REG_NONE : `REG_BP;
        r.index = (rmf[2:1] == 2'b11) ? `REG_NONE : (rmf[0] ? `REG_DI : `REG_SI);
        r.seg   = ((rmf[2:1] == 2'b01) || ((rmf == 3'b110) && !direct)) ?
                  decode_pkg::SEG_SS : decode_pkg::SEG_DS;
        r.word_op = op[0];

        if ((op[7:6] == 2'b00) && !op[2])
            d_form = 1'b1; // ALU r/m, reg
        else if ((op[7:6] == 2'b00) && (op[2:1] == 2'b10))
        begin
            r.need_imm = 1'b1;
            r.imm_size = op[0];
        end
        else if (op[7:5] == 3'b010)
            r.src = {1'b0, op[2:0]};
        else if ((op[7:4] == 4'b0111) || (op == 8'hEB))
            r.need_disp = 1'b1;
        else if ((op == 8'hE8) || (op == 8'hE9))
        begin
            r.need_disp = 1'b1;
            r.disp_size = 1'b1;
        end
        else if (op[7:2] == 6'b100000)
        begin
            mem_form   = 1'b1;
            r.need_imm = 1'b1;
            r.imm_size = op[0] && !op[1];
            r.dst      = {1'b0, rmf};
        end
        else if ((op[7:2] == 6'b100001) || (op[7:2] == 6'b100010))
            d_form = 1'b1; // TEST, XCHG, MOV
        else if (op[7:4] == 4'b1011)
        begin
            r.need_imm = 1'b1;
            r.imm_size = op[3];
            r.word_op  = op[3];
            r.dst      = {1'b0, op[2:0]};
        end
        else if (op[7:2] == 6'b110100)
        begin
            mem_form = 1'b1;
            r.dst    = {1'b0, rmf};
            r.src    = {1'b0, rmf};
        end
        else
            r.not_decoded = 1'b1;

        if (d_form)
        begin
            mem_form = 1'b1;
            r.dst    = op[1] ? {1'b0, rg} : {1'b0, rmf};
            r.src    = op[1] ? {1'b0, rmf} : {1'b0, rg};
        end
        if (mem_form)
        begin
            r.need_modrm = 1'b1;
            r.need_disp  = direct || (md == 2'b01) || (md == 2'b10);
            r.disp_size  = direct || md[1];
        end
        return r;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [3:0] exp, input logic [3:0] act);
        check_count++;
        if (act !== exp)
        begin
            $display("error %s %s expected %0h actual %0h", test, field, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_result(input string test, input decode_pkg::decode_t exp,
                                  input decode_pkg::decode_t act);
        check_field(test, "need_modrm", exp.need_modrm, act.need_modrm);
        check_field(test, "need_disp", exp.need_disp, act.need_disp);
        check_field(test, "disp_size", exp.disp_size, act.disp_size);
        check_field(test, "need_imm", exp.need_imm, act.need_imm);
        check_field(test, "imm_size", exp.imm_size, act.imm_size);
        check_field(test, "word_op", exp.word_op, act.word_op);
        check_field(test, "not_decoded", exp.not_decoded, act.not_decoded);
        check_field(test, "src", exp.src, act.src);
        check_field(test, "dst", exp.dst, act.dst);
        check_field(test, "base", exp.base, act.base);
        check_field(test, "index", exp.index, act.index);
        check_field(test, "seg", exp.seg, act.seg);
    endtask

    task automatic check_drained();
        if (pending.size() != 0)
        begin
            $display("%0d strobed instructions never produced decoded_valid", pending.size());
            error_count++;
        end
    endtask

    // Values seen here are the ones from before this edge
    always @(posedge clk)
    begin
        if (armed)
        begin
            if (reset_seen)
            begin
                if (decoded_valid !== 1'b0)
                begin
                    $display("decoded_valid was high right after a reset edge");
                    error_count++;
                end
                compare_result("reset", '0, actual);
            end
            else if (decoded_valid === 1'b1)
            begin
                if (pending.size() == 0)
                begin
                    $display("decoded_valid arrived with no strobe pending");
                    error_count++;
                end
                else
                begin
                    entry = pending.pop_front();
                    compare_result(test_name(entry[19:16]),
                                   expected_decode(entry[15:8], entry[7:0]), actual);
                end
            end
            else
            begin
                compare_result("hold", held, actual); // Idle cycle keeps the last result
            end
            held = actual;
            if (!reset_seen && (decoded_valid !== strobed))
            begin
                $display("decoded_valid did not come exactly one cycle after its strobe");
                error_count++;
            end
        end
        if (rst_n && instr_valid)
            pending.push_back({test_id, opcode, modrm});
        strobed = rst_n && instr_valid;
        if (!rst_n)
            armed = 1'b1;
        reset_seen = !rst_n;
    end

endmodule

// File: bench/tb_decode.sv
/* 8086 decoder testbench
   Directed sweeps, LFSR random traffic and a mid-run reset against the scoreboard */

`timescale 1ns/1ps

module tb_decode;

    localparam int test_cycles   = 2 * 256 + 4 * 256 + 2000 + 32; // Sweeps, random, reset
    localparam int margin_cycles = 200;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                instr_valid;
    logic [7:0]          opcode;
    logic [7:0]          modrm;
    logic [3:0]          test_id;
    logic                need_modrm;
    logic                need_disp;
    logic                disp_size;
    logic                need_imm;
    logic                imm_size;
    logic                word_op;
    logic                not_decoded;
    decode_pkg::reg_id_t src;
    decode_pkg::reg_id_t dst;
    decode_pkg::reg_id_t base;
    decode_pkg::reg_id_t index;
    decode_pkg::seg_t    seg;
    logic                decoded_valid;
    logic [31:0]         lfsr;
    logic [7:0]          rand_op;
    logic [7:0]          rand_m;
    logic [7:0]          gap;
    int                  i;
    int                  j;
    int                  total_errors;

    always #5 clk = ~clk;

    decode_top dut_i
    (
        .clk (clk), .rst_n (rst_n), .instr_valid (instr_valid),
        .opcode (opcode), .modrm (modrm),
        .need_modrm (need_modrm), .need_disp (need_disp), .disp_size (disp_size),
        .need_imm (need_imm), .imm_size (imm_size), .word_op (word_op),
        .not_decoded (not_decoded), .src (src), .dst (dst), .base (base),
        .index (index), .seg (seg), .decoded_valid (decoded_valid)
    );

    decode_checker checker_i
    (
        .clk (clk), .rst_n (rst_n), .instr_valid (instr_valid),
        .opcode (opcode), .modrm (modrm), .test_id (test_id),
        .need_modrm (need_modrm), .need_disp (need_disp), .disp_size (disp_size),
        .need_imm (need_imm), .imm_size (imm_size), .word_op (word_op),
        .not_decoded (not_decoded), .src (src), .dst (dst), .base (base),
        .index (index), .seg (seg), .decoded_valid (decoded_valid)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic strobe(input logic [7:0] op, input logic [7:0] m, input logic [3:0] id);
        @(posedge clk);
        instr_valid <= 1'b1;
        opcode      <= op;
        modrm       <= m;
        test_id     <= id;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            instr_valid <= 1'b0;
            opcode      <= ~opcode; // Inputs keep moving while no strobe is given
            modrm       <= ~modrm;
        end
    endtask

    initial
    begin
        #((test_cycles + margin_cycles) * 10);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        opcode      = 8'h00;
        modrm       = 8'h00;
        test_id     = 4'd0;
        lfsr        = 32'h21d4;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < 256; i++)
            strobe(8'h00, i[7:0], 4'd1); // ADD r/m,r
        for (i = 0; i < 256; i++)
            strobe(8'h02, i[7:0], 4'd2); // ADD r,r/m
        idle(2);

        for (i = 0; i < 256; i++)
        begin
            for (j = 0; j < 4; j++)
            begin
                take_bits(6, rand_m);
                strobe(i[7:0], {j[1:0], rand_m[5:0]}, 4'd3); // Every mod per opcode
            end
        end
        idle(2);

        for (i = 0; i < 2000; i++)
        begin
            take_bits(2, gap);
            if (gap[1:0] == 2'b00)
                idle(1); // About one idle cycle in four
            else
            begin
                take_bits(8, rand_op);
                take_bits(8, rand_m);
                strobe(rand_op, rand_m, 4'd4);
            end
        end
        idle(3);

        @(posedge clk);
        rst_n <= 1'b0;
        idle(2);
        rst_n <= 1'b1;
        for (i = 0; i < 16; i++)
        begin
            take_bits(8, rand_op);
            take_bits(8, rand_m);
            strobe(rand_op, rand_m, 4'd5);
        end
        idle(4);

        checker_i.check_drained();
        total_errors = checker_i.error_count + dut_i.register_i.assert_i.fail_count;
        $display("Checks %0d, checker errors %0d, assertion failures %0d",
                 checker_i.check_count, checker_i.error_count,
                 dut_i.register_i.assert_i.fail_count);
        if (total_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: decode_top.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/ea_if.sv
verilog/modrm_decode.sv
verilog/opcode_decode.sv
verilog/decode_register.sv
verilog/decode_top.sv
bench/decode_assert.sv
bench/decode_checker.sv
bench/tb_decode.sv

// File: Bender.yml
package:
  name: decode_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/decode_pkg.sv
      - verilog/ea_if.sv
      - verilog/modrm_decode.sv
      - verilog/opcode_decode.sv
      - verilog/decode_register.sv
      - verilog/decode_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/decode_assert.sv
      - bench/decode_checker.sv
      - bench/tb_decode.sv
